// ==== all.f ====
common/lsuBusPkg.sv
busfsm/busFsm.sv
logic/ahbMaster.sv
logic/readCapture.sv
logic/lsuBus.sv
sim/clockGen.sv
sim/ahbMemModel.sv
sim/lsuBusTb.sv

// ==== Makefile ====
.PHONY: all run lint clean

all: run

obj_dir/VlsuBusTb: all.f $(shell cat all.f)
	verilator --binary --timing --assert -f all.f --top-module lsuBusTb -Mdir obj_dir

run: obj_dir/VlsuBusTb
	@out="$$(./obj_dir/VlsuBusTb)"; echo "$$out"; echo "$$out" | grep -qx "No errors"

lint:
	verilator --lint-only --timing -f all.f --top-module lsuBusTb

clean:
	rm -rf obj_dir

// ==== sim/lsuBusTb.sv ====
// Table-driven testbench for lsuBus; table addresses must stay below 1024 to fit the memory model
module lsuBusTb;

  import lsuBusPkg::*;

  // One table row holds the request, data, ignore flag, CPU-busy cycles and transfer flag
  typedef struct packed {
    rwT         rw;
    addrT       addr;
    wordT       wdata;
    logic       ignoreReq;
    logic [3:0] busyCycles;
    logic       expectXfer;
  } entryT;

  logic clk;
  logic reset;
  addrT Addr;
  wordT WriteData;
  rwT   RW;
  logic IgnoreRequest;
  logic CpuBusy;
  logic BusStall;
  logic BusCommitted;
  wordT ReadData;
  addrT HADDR;
  logic HWRITE;
  htransT HTRANS;
  wordT HWDATA;
  wordT HRDATA;
  logic HREADY;

  entryT stim[$];
  wordT  shadowMem [256];
  wordT  lastRead = '0;
  logic [31:0] lcgState = 32'h8469;
  int errorCount = 0;
  int checkCount = 0;
  int cycleCount = 0;
  int cycleLimit = 0;
  int addrPhaseCount = 0;

  clockGen clockGen_i (.clk(clk), .reset(reset));

  lsuBus dut_i (
    .clk(clk), .reset(reset), .Addr(Addr), .WriteData(WriteData), .RW(RW),
    .IgnoreRequest(IgnoreRequest), .CpuBusy(CpuBusy), .BusStall(BusStall),
    .BusCommitted(BusCommitted), .ReadData(ReadData), .HADDR(HADDR), .HWRITE(HWRITE),
    .HTRANS(HTRANS), .HWDATA(HWDATA), .HRDATA(HRDATA), .HREADY(HREADY)
  );

  ahbMemModel ahbMemModel_i (
    .clk(clk), .reset(reset), .HADDR(HADDR), .HWRITE(HWRITE), .HTRANS(HTRANS),
    .HWDATA(HWDATA), .HRDATA(HRDATA), .HREADY(HREADY)
  );

  //////////////////////
  // Helpers
  //////////////////////

  function automatic logic [31:0] lcgStep();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // Called by the memory model at each accepted address phase and returns 0 to 3 waits
  function automatic logic [1:0] drawWaitStates();
    logic [31:0] r;
    r = lcgStep();
    return r[17:16];
  endfunction

  task automatic compareValues(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("CHECK FAILED at time %0t: %s (got %h, expected %h)", $time, what, actual,
               expected);
    end
  endtask

  task automatic addEntry(input rwT rw, input addrT addr, input wordT wdata,
                          input logic ignoreReq, input int busy, input logic xfer);
    entryT e;
    e.rw = rw;
    e.addr = addr;
    e.wdata = wdata;
    e.ignoreReq = ignoreReq;
    e.busyCycles = 4'(busy);
    e.expectXfer = xfer;
    stim.push_back(e);
  endtask

  // Starts and ends 1 unit after a rising edge with the sequencer back in ready
  task automatic runEntry(input int idx);
    entryT e;
    wordT  expectedRead;
    logic  isWrite;
    int    errorsBefore;
    e = stim[idx];
    errorsBefore = errorCount;
    // Write wins when both request bits are set
    isWrite = e.rw[0];
    expectedRead = shadowMem[e.addr[9:2]];
    RW = e.rw;
    Addr = e.addr;
    WriteData = e.wdata;
    IgnoreRequest = e.ignoreReq;
    CpuBusy = (e.busyCycles != 4'd0);
    #1;
    if (e.expectXfer) begin
      compareValues(32'(BusStall), 32'd1, "stall in request cycle");
      compareValues(32'(HTRANS), 32'(htransNonseq), "NONSEQ in request cycle");
      compareValues(HADDR, e.addr, "HADDR at acceptance");
      compareValues(32'(HWRITE), 32'(isWrite), "HWRITE at acceptance");
      compareValues(32'(HREADY), 32'd1, "slave ready at acceptance");
      @(posedge clk);
      #1;
      // The master holds the write word through the data phase
      if (isWrite) begin
        compareValues(HWDATA, e.wdata, "HWDATA in data phase");
      end
      while (BusStall) begin
        @(posedge clk);
        #1;
      end
      // Now in the done cycle
      if (!isWrite) begin
        compareValues(ReadData, expectedRead, "read data");
        lastRead = expectedRead;
      end else begin
        compareValues(ReadData, lastRead, "ReadData kept across write");
        shadowMem[e.addr[9:2]] = e.wdata;
      end
      RW = rwNone;
      IgnoreRequest = 1'b0;
      for (int k = 0; k < int'(e.busyCycles); k++) begin
        compareValues(32'(BusCommitted), 32'd1, "committed while CPU busy");
        compareValues(32'(BusStall), 32'd0, "no stall while CPU busy");
        @(posedge clk);
        #1;
      end
      CpuBusy = 1'b0;
      compareValues(32'(BusCommitted), 32'd1, "committed before ready");
      @(posedge clk);
      #1;
      compareValues(32'(BusCommitted), 32'd0, "committed after return to ready");
      compareValues(32'(BusStall), 32'd0, "stall after return to ready");
    end else begin
      compareValues(32'(BusStall), 32'd0, "no stall on ignored request");
      compareValues(32'(HTRANS), 32'(htransIdle), "IDLE on ignored request");
      @(posedge clk);
      #1;
      compareValues(32'(BusCommitted), 32'd0, "not committed on ignored request");
      compareValues(ReadData, lastRead, "ReadData kept on ignored request");
      RW = rwNone;
      IgnoreRequest = 1'b0;
      CpuBusy = 1'b0;
    end
    $display("Entry %0d rw=%b addr=%h: %s", idx, e.rw, e.addr,
             (errorCount == errorsBefore) ? "pass" : "FAIL");
  endtask

  //////////////////////
  // Monitors
  //////////////////////

  // An address phase is taken at the next edge when NONSEQ and HREADY are both high
  always @(negedge clk) begin
    if (!reset && HTRANS == htransNonseq && HREADY) begin
      addrPhaseCount++;
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("Errors found");
      $finish;
    end
  end

  //////////////////////
  // Main sequence
  //////////////////////

  initial begin
    int maxBusy;
    int expectedPhases;
    RW = rwNone;
    Addr = '0;
    WriteData = '0;
    IgnoreRequest = 1'b0;
    CpuBusy = 1'b0;
    maxBusy = 0;
    expectedPhases = 0;
    for (int i = 0; i < 256; i++) begin
      shadowMem[i] = 32'(i) * 32'h9E3779B9;
    end
    addEntry(rwRead,  32'h000, 32'h0, 1'b0, 0, 1'b1);
    addEntry(rwRead,  32'h104, 32'h0, 1'b0, 0, 1'b1);
    addEntry(rwWrite, 32'h010, 32'hCAFE0001, 1'b0, 0, 1'b1);
    addEntry(rwRead,  32'h010, 32'h0, 1'b0, 0, 1'b1);
    addEntry(rwWrite, 32'h3FC, 32'hA5A55A5A, 1'b0, 2, 1'b1);
    addEntry(rwRead,  32'h3FC, 32'h0, 1'b0, 1, 1'b1);
    addEntry(rwRead,  32'h020, 32'h0, 1'b1, 0, 1'b0);
    addEntry(rwWrite, 32'h010, 32'hDEADBEEF, 1'b1, 0, 1'b0);
    addEntry(rwRead,  32'h010, 32'h0, 1'b0, 0, 1'b1);
    addEntry(2'b11,   32'h040, 32'h12345678, 1'b0, 0, 1'b1);
    addEntry(rwRead,  32'h040, 32'h0, 1'b0, 3, 1'b1);
    addEntry(rwWrite, 32'h044, 32'h0F0F1234, 1'b0, 4, 1'b1);
    addEntry(rwRead,  32'h044, 32'h0, 1'b0, 0, 1'b1);
    addEntry(rwRead,  32'h200, 32'h0, 1'b0, 2, 1'b1);
    addEntry(2'b11,   32'h010, 32'h600DF00D, 1'b0, 0, 1'b1);
    addEntry(rwRead,  32'h010, 32'h0, 1'b0, 0, 1'b1);
    foreach (stim[i]) begin
      if (int'(stim[i].busyCycles) > maxBusy) begin
        maxBusy = int'(stim[i].busyCycles);
      end
      if (stim[i].expectXfer) begin
        expectedPhases++;
      end
    end
    cycleLimit = stim.size() * (3 + maxBusy + 6) + 20;
    wait (!reset);
    @(posedge clk);
    #1;
    compareValues(32'(BusStall), 32'd0, "stall after reset");
    compareValues(32'(BusCommitted), 32'd0, "committed after reset");
    compareValues(32'(HTRANS), 32'(htransIdle), "HTRANS after reset");
    compareValues(ReadData, 32'h0, "ReadData after reset");
    foreach (stim[i]) begin
      runEntry(i);
    end
    compareValues(32'(addrPhaseCount), 32'(expectedPhases), "address phase count");
    $display("%0d entries, %0d checks, %0d errors", stim.size(), checkCount, errorCount);
    if (errorCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== sim/ahbMemModel.sv ====
// Word-addressed AHB-Lite slave of 256 words at addresses 0 to 1023; no pipelined transfers and no error response
module ahbMemModel (
  input  logic                clk,
  input  logic                reset,
  input  lsuBusPkg::addrT     HADDR,
  input  logic                HWRITE,
  input  lsuBusPkg::htransT   HTRANS,
  input  lsuBusPkg::wordT     HWDATA,
  output lsuBusPkg::wordT     HRDATA,
  output logic                HREADY
);

  import lsuBusPkg::*;

  localparam int memWords = 256;
  localparam wordT fillMult = 32'h9E3779B9;

  wordT mem [memWords];

  // Data phase bookkeeping for the one transfer in flight
  logic       dataActive;
  logic       dataWrite;
  logic [7:0] dataIndex;
  logic [1:0] waitLeft;

  // Ready whenever no data phase is open, otherwise once the wait states run out
  assign HREADY = !dataActive || (waitLeft == 2'd0);
  assign HRDATA = (dataActive && !dataWrite) ? mem[dataIndex] : '0;

  //////////////////////
  // Slave sequencing
  //////////////////////

  always @(posedge clk) begin
    if (reset) begin
      dataActive <= 1'b0;
      dataWrite  <= 1'b0;
      dataIndex  <= '0;
      waitLeft   <= '0;
      // Every word starts as its word address times the fill constant
      for (int i = 0; i < memWords; i++) begin
        mem[i] <= wordT'(i) * fillMult;
      end
    end else if (!HREADY) begin
      waitLeft <= waitLeft - 2'd1;
    end else begin
      // A write lands on the edge that closes its data phase
      if (dataActive && dataWrite) begin
        mem[dataIndex] <= HWDATA;
      end
      if (HTRANS == htransNonseq) begin
        dataActive <= 1'b1;
        dataWrite  <= HWRITE;
        dataIndex  <= HADDR[9:2];
        // Wait states for this transfer come from the testbench generator
        waitLeft   <= lsuBusTb.drawWaitStates();
      end else begin
        dataActive <= 1'b0;
      end
    end
  end

endmodule

// ==== sim/clockGen.sv ====
// Free-running testbench clock with an 8-unit period; reset is held for the first 10 rising edges
module clockGen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Reset drops just after an edge, like every other driven input
  initial begin
    reset = 1'b1;
    repeat (10) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

// ==== logic/lsuBus.sv ====
// Uncached load/store bus path; one word per request and the core must hold its request while stalled
module lsuBus (
  input  logic                clk,
  input  logic                reset,
  // Core side
  input  lsuBusPkg::addrT     Addr,
  input  lsuBusPkg::wordT     WriteData,
  input  lsuBusPkg::rwT       RW,
  input  logic                IgnoreRequest,
  input  logic                CpuBusy,
  output logic                BusStall,
  output logic                BusCommitted,
  output lsuBusPkg::wordT     ReadData,
  // AHB-Lite side
  output lsuBusPkg::addrT     HADDR,
  output logic                HWRITE,
  output lsuBusPkg::htransT   HTRANS,
  output lsuBusPkg::wordT     HWDATA,
  input  lsuBusPkg::wordT     HRDATA,
  input  logic                HREADY
);

  // Transfer levels from the sequencer to the master
  logic busRead;
  logic busWrite;
  // End of the data phase, seen by the sequencer and the capture buffer
  logic busAck;
  // Read in progress, arms the capture buffer
  logic captureEn;

  ////////////////////
  // Sequencer
  ////////////////////

  busFsm busFsm_i (
    .clk           (clk),
    .reset         (reset),
    .IgnoreRequest (IgnoreRequest),
    .RW            (RW),
    .BusAck        (busAck),
    .CpuBusy       (CpuBusy),
    .BusStall      (BusStall),
    .BusRead       (busRead),
    .BusWrite      (busWrite),
    .CaptureEn     (captureEn),
    .BusCommitted  (BusCommitted)
  );

  // AHB-Lite master
  ahbMaster ahbMaster_i (
    .clk       (clk),
    .reset     (reset),
    .BusRead   (busRead),
    .BusWrite  (busWrite),
    .Addr      (Addr),
    .WriteData (WriteData),
    .HREADY    (HREADY),
    .HADDR     (HADDR),
    .HWRITE    (HWRITE),
    .HTRANS    (HTRANS),
    .HWDATA    (HWDATA),
    .BusAck    (busAck)
  );

  // Read data buffer for the core
  readCapture readCapture_i (
    .clk       (clk),
    .reset     (reset),
    .CaptureEn (captureEn),
    .BusAck    (busAck),
    .HRDATA    (HRDATA),
    .ReadData  (ReadData)
  );

endmodule

// ==== logic/readCapture.sv ====
// Holds the last loaded word until the next read completes; writes and ignored requests leave it alone
module readCapture (
  input  logic              clk,
  input  logic              reset,
  input  logic              CaptureEn,
  input  logic              BusAck,
  input  lsuBusPkg::wordT   HRDATA,
  output lsuBusPkg::wordT   ReadData
);

  // Load strobe for the one cycle in which read data is on HRDATA
  logic loadWord;

  ////////////////////
  // Capture register
  ////////////////////

  // BusAck marks the final data phase cycle of any transfer
  // CaptureEn narrows that down to reads
  assign loadWord = CaptureEn & BusAck;

  // Cleared on reset so the core sees zero before the first load
  always_ff @(posedge clk) begin
    if (reset) begin
      ReadData <= '0;
    end else if (loadWord) begin
      ReadData <= HRDATA;
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  // Outside a read the word must survive, including across a completing write
  assertNoStrayLoad: assert property (
    @(posedge clk) disable iff (reset)
      !CaptureEn |=> $stable(ReadData)
  ) else $error("ReadData changed outside a read");

endmodule

// ==== logic/ahbMaster.sv ====
// Single-word AHB-Lite master with no bursts, locking or error handling; Addr must stay stable until BusAck
module ahbMaster (
  input  logic                clk,
  input  logic                reset,
  input  logic                BusRead,
  input  logic                BusWrite,
  input  lsuBusPkg::addrT     Addr,
  input  lsuBusPkg::wordT     WriteData,
  input  logic                HREADY,
  output lsuBusPkg::addrT     HADDR,
  output logic                HWRITE,
  output lsuBusPkg::htransT   HTRANS,
  output lsuBusPkg::wordT     HWDATA,
  output logic                BusAck
);

  import lsuBusPkg::*;

  // Tracks which half of the one transfer is on the bus
  // The request levels stay high through the data phase, so this register is what
  // keeps a second NONSEQ from going out for the same request
  typedef enum logic {
    phAddr,
    phData
  } phaseT;

  phaseT phase;
  phaseT phaseNext;

  // High when some direction is requested by the sequencer
  logic busReq;
  // Address phase sampled by the slave at this edge
  logic addrAccept;

  assign busReq = BusRead | BusWrite;

  ////////////////////
  // Address phase
  ////////////////////

  // NONSEQ only while the address is still pending, IDLE once the data phase starts
  assign HTRANS = (busReq && phase == phAddr) ? htransNonseq : htransIdle;

  // Address and direction come straight from the core side
  // They are only meaningful while HTRANS is NONSEQ
  assign HADDR  = Addr;
  assign HWRITE = BusWrite;

  // The slave takes the address at an edge where NONSEQ and HREADY are both high
  assign addrAccept = (HTRANS == htransNonseq) & HREADY;

  ////////////////////
  // Phase tracking
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= phAddr;
    end else begin
      phase <= phaseNext;
    end
  end

  always_comb begin
    phaseNext = phase;
    case (phase)
      phAddr: begin
        if (addrAccept) begin
          phaseNext = phData;
        end
      end
      phData: begin
        // Wait states stretch the data phase until HREADY returns
        if (HREADY) begin
          phaseNext = phAddr;
        end
      end
      default: begin
        phaseNext = phAddr;
      end
    endcase
  end

  // Write data is captured as the address is accepted and held through the data phase
  always_ff @(posedge clk) begin
    if (addrAccept && BusWrite) begin
      HWDATA <= WriteData;
    end
  end

  // Completion is the last data phase cycle, so HRDATA is valid alongside it
  assign BusAck = (phase == phData) & HREADY;

  ////////////////////
  // Checks
  ////////////////////

  // A stalled address phase must be repeated unchanged
  // This relies on the sequencer holding its level and the core holding Addr
  assertAddrHold: assert property (
    @(posedge clk) disable iff (reset)
      (HTRANS == htransNonseq && !HREADY) |=>
        (HTRANS == htransNonseq && $stable(HADDR) && $stable(HWRITE))
  ) else $error("Address phase changed while HREADY was low");

endmodule

// ==== busfsm/busFsm.sv ====
// Assumes the core holds RW stable while BusStall is high and that BusAck only pulses once per transfer
module busFsm (
  input  logic              clk,
  input  logic              reset,
  input  logic              IgnoreRequest,
  input  lsuBusPkg::rwT     RW,
  input  logic              BusAck,
  input  logic              CpuBusy,
  output logic              BusStall,
  output logic              BusRead,
  output logic              BusWrite,
  output logic              CaptureEn,
  output logic              BusCommitted
);

  import lsuBusPkg::*;

  // One state per phase of an uncached access
  // The done states last exactly one cycle and release the stall
  typedef enum logic [2:0] {
    stReady,
    stWrite,
    stWriteDone,
    stRead,
    stReadDone,
    stCpuBusy
  } busStateT;

  busStateT curState;
  busStateT nextState;

  // Decoded view of the core request
  logic reqValid;
  logic reqWrite;
  logic reqRead;
  logic inReady;

  ////////////////////
  // Request decode
  ////////////////////

  // A request counts only when some bit is set and the core has not told us to drop it
  assign reqValid = ~IgnoreRequest & (RW != rwNone);
  assign reqWrite = (RW & rwWrite) != rwNone;
  assign reqRead  = (RW & rwRead) != rwNone;
  assign inReady  = curState == stReady;

  ////////////////////
  // State register
  ////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      curState <= stReady;
    end else begin
      curState <= nextState;
    end
  end

  // Next state logic
  // Write is checked before read so a read-plus-write request becomes a write
  always_comb begin
    nextState = curState;
    case (curState)
      stReady: begin
        if (reqValid && reqWrite) begin
          nextState = stWrite;
        end else if (reqValid && reqRead) begin
          nextState = stRead;
        end
      end
      stWrite: begin
        // Stay here for as many wait states as the slave inserts
        if (BusAck) begin
          nextState = stWriteDone;
        end
      end
      stRead: begin
        if (BusAck) begin
          nextState = stReadDone;
        end
      end
      stWriteDone, stReadDone, stCpuBusy: begin
        // The core may still be busy with something else when the result is ready
        // Stay committed until it lets go
        if (CpuBusy) begin
          nextState = stCpuBusy;
        end else begin
          nextState = stReady;
        end
      end
      default: begin
        nextState = stReady;
      end
    endcase
  end

  ////////////////////
  // Outputs
  ////////////////////

  // The stall rises combinationally in the request cycle and holds until BusAck
  assign BusStall = (inReady & reqValid) | (curState == stWrite) | (curState == stRead);

  // Transfer levels also start in the request cycle so the address phase is not delayed
  assign BusWrite = (inReady & reqValid & reqWrite) | (curState == stWrite);

  // A read is suppressed when the write bit is also set
  assign BusRead = (inReady & reqValid & reqRead & ~reqWrite) | (curState == stRead);

  // Capture is armed for the whole of a read, the buffer itself waits for BusAck
  assign CaptureEn = BusRead;

  // Committed covers everything after the request cycle up to the return to ready
  assign BusCommitted = ~inReady;

  ////////////////////
  // Checks
  ////////////////////

  // Only one direction may be requested from the master at a time
  assertOneDir: assert property (
    @(posedge clk) disable iff (reset) !(BusRead && BusWrite)
  ) else $error("BusRead and BusWrite are both high");

  // The master may only finish a transfer that this sequencer is waiting on
  assertAckInTransfer: assert property (
    @(posedge clk) disable iff (reset)
      BusAck |-> (curState == stRead || curState == stWrite)
  ) else $error("BusAck arrived outside a read or write");

endmodule

// ==== common/lsuBusPkg.sv ====
// Widths are fixed at 32 bits and every bus transfer is one full word, so nothing here is sized per instance
package lsuBusPkg;

  ////////////////////
  // Bus widths
  ////////////////////

  // Data word width on both the core side and the AHB data buses
  localparam int wordBits = 32;

  // Byte address width, the same on the core side and on HADDR
  localparam int addrBits = 32;

  // A data word as it moves between the core and the AHB data buses
  typedef logic [wordBits-1:0] wordT;

  // A byte address, passed straight through to HADDR
  typedef logic [addrBits-1:0] addrT;

  ////////////////////
  // Core request
  ////////////////////

  // The core request is a two-bit mask
  // Bit 0 asks for a write and bit 1 asks for a read
  // When both bits are set the write is performed and the read is dropped
  typedef logic [1:0] rwT;

  // No access this cycle
  localparam rwT rwNone  = 2'b00;
  // Store one word to Addr
  localparam rwT rwWrite = 2'b01;
  // Load one word from Addr
  localparam rwT rwRead  = 2'b10;

  ////////////////////
  // AHB transfer type
  ////////////////////

  // Standard AHB HTRANS encoding
  // Only IDLE and NONSEQ are driven by this unit since it never bursts
  typedef enum logic [1:0] {
    htransIdle   = 2'b00,
    htransBusy   = 2'b01,
    htransNonseq = 2'b10,
    htransSeq    = 2'b11
  } htransT;

endpackage
